//--- compile.f
+incdir+include
hw/merge_cfg_pkg.sv
hw/merge_data_pkg.sv
hw/port_fifo.sv
hw/rr_arb_tree.sv
hw/merge_ctrl_regs.sv
hw/stream_merge_top.sv
sim/tb_stream_merge.sv

//--- Bender.yml
package:
  name: stream_merge

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/merge_cfg_pkg.sv
      - hw/merge_data_pkg.sv
      - hw/port_fifo.sv
      - hw/rr_arb_tree.sv
      - hw/merge_ctrl_regs.sv
      - hw/stream_merge_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_stream_merge.sv

//--- sim/tb_stream_merge.sv
// testbench of the four-port stream merger
// table-driven pushes, per-port reference queues and a rotation model
// APB tasks for control, status and beat counters

`timescale 1ns/100ps
`include "merge_defines.svh"

module tb_stream_merge;
  import merge_cfg_pkg::*;
  import merge_data_pkg::*;

  // phase boundaries inside the stimulus table
  localparam int A_BASE     = 0;
  localparam int B_BASE     = 4;
  localparam int C_BASE     = 20;
  localparam int E_ONE      = 28;
  localparam int E_DROP     = 29;
  localparam int E_ROUND    = 31;
  localparam int NUM_STEPS  = 35;
  localparam int MAX_CYCLES = NUM_STEPS * 8 + 200;

  typedef struct packed {
    port_idx_t port;
    payload_t  data;
    logic      stall;
  } step_t;

  logic                              clk;
  logic                              rst_n;
  logic                              psel;
  logic                              penable;
  logic                              pwrite;
  apb_addr_t                         paddr;
  logic [31:0]                       pwdata;
  logic [31:0]                       prdata;
  logic                              pready;
  logic                              pslverr;
  logic [`MERGE_NUM_PORTS-1:0]       in_valid;
  payload_t [`MERGE_NUM_PORTS-1:0]   in_data;
  logic [`MERGE_NUM_PORTS-1:0]       in_ready;
  logic                              out_valid;
  out_beat_t                         out_beat;
  logic                              out_ready;

  // stimulus and expected beats
  step_t       stim [NUM_STEPS];
  out_beat_t   exp_tbl [NUM_STEPS];
  // reference model state
  payload_t    ref_q [`MERGE_NUM_PORTS][$];
  int unsigned ref_cnt [`MERGE_NUM_PORTS];
  logic [1:0]  rr_model;
  logic [3:0]  en_model;
  int unsigned cycle_cnt;

  stream_merge_top UUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .paddr_i     (paddr),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr),
    .in_valid_i  (in_valid),
    .in_data_i   (in_data),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_beat_o  (out_beat),
    .out_ready_i (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run limit from the table length
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      end_with_failure();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////////////////////////
  task automatic end_with_failure();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // APB access
  //////////////////////////////////////////////////////////////////////
  task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    check_value("pready_o", pready, 1'b1);
    check_value("pslverr_o", pslverr, 1'b0);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output logic [31:0] data,
                          output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    // read data is valid in the access phase
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    check_value("pready_o", pready, 1'b1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_check(input apb_addr_t addr, input logic [31:0] exp,
                            input string name);
    logic [31:0] rdata;
    logic        err;
    apb_read(addr, rdata, err);
    check_value("pslverr_o", err, 1'b0);
    check_value(name, rdata, exp);
  endtask

  // control write, model follows the effective port enables
  task automatic set_ctrl(input logic [31:0] value);
    apb_write(REG_CTRL, value);
    en_model = value[0] ? value[7:4] : 4'b0000;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table and reference model
  //////////////////////////////////////////////////////////////////////
  task automatic fill_table();
    int p;
    for (int i = 0; i < NUM_STEPS; i++) begin
      if (i < B_BASE) p = 2;
      else if (i < C_BASE) p = (i - B_BASE) % 4;
      else if (i < E_ONE) p = (i - C_BASE) % 4;
      else if (i == E_ONE) p = 1;
      else if (i < E_ROUND) p = (i == E_DROP) ? 0 : 3;
      else p = i - E_ROUND;
      stim[i].port  = port_idx_t'(p);
      // step index in the top byte keeps payloads distinct
      stim[i].data  = {8'(i), 24'($urandom)};
      stim[i].stall = (($urandom % 3) == 0) || (i == B_BASE + 1);
    end
  endtask

  // two levels of pairwise choice steered by the pointer bits
  function automatic int pick_port(input logic [3:0] req, input logic [1:0] ptr);
    int lo;
    int hi;
    lo = (!req[0] || (req[1] && ptr[0])) ? 1 : 0;
    hi = (!req[2] || (req[3] && ptr[0])) ? 3 : 2;
    if (!(req[0] || req[1]) || ((req[2] || req[3]) && ptr[1])) begin
      return hi;
    end
    return lo;
  endfunction

  // fill exp_tbl with the next n beats the merger must produce
  task automatic predict_beats(input int n);
    logic [3:0] req;
    int         p;
    for (int k = 0; k < n; k++) begin
      for (int i = 0; i < `MERGE_NUM_PORTS; i++) begin
        req[i] = (ref_q[i].size() != 0) && en_model[i];
      end
      if (req == 4'b0000) begin
        $display("reference model has no enabled word left to predict");
        end_with_failure();
      end
      p = pick_port(req, rr_model);
      exp_tbl[k].src  = port_idx_t'(p);
      exp_tbl[k].data = ref_q[p].pop_front();
      ref_cnt[p]++;
      rr_model = rr_model + 2'd1;
    end
  endtask

  task automatic flush_model();
    for (int i = 0; i < `MERGE_NUM_PORTS; i++) begin
      ref_q[i].delete();
      ref_cnt[i] = 0;
    end
    rr_model = 2'd0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stream drivers
  //////////////////////////////////////////////////////////////////////
  task automatic push_word(input int p, input payload_t d);
    @(posedge clk);
    in_valid[p] <= 1'b1;
    in_data[p]  <= d;
    @(negedge clk);
    while (!in_ready[p]) @(negedge clk);
    // word is taken on this edge
    @(posedge clk);
    in_valid[p] <= 1'b0;
    ref_q[p].push_back(d);
  endtask

  task automatic load_steps(input int base, input int n);
    for (int i = base; i < base + n; i++) begin
      push_word(stim[i].port, stim[i].data);
    end
  endtask

  task automatic take_beat(input out_beat_t exp, input logic stall);
    out_beat_t   held;
    int unsigned wait_n;
    @(negedge clk);
    while (!out_valid) @(negedge clk);
    check_value("out_beat_o.src", out_beat.src, exp.src);
    check_value("out_beat_o.data", out_beat.data, exp.data);
    held = out_beat;
    if (stall) begin
      wait_n = 1 + ($urandom % 3);
      repeat (wait_n) begin
        @(negedge clk);
        check_value("out_valid_o", out_valid, 1'b1);
        check_value("out_beat_o", out_beat, held);
      end
    end
    @(posedge clk);
    out_ready <= 1'b1;
    @(negedge clk);
    check_value("out_valid_o", out_valid, 1'b1);
    check_value("out_beat_o", out_beat, held);
    // handshake completes on this edge
    @(posedge clk);
    out_ready <= 1'b0;
  endtask

  task automatic drain_beats(input int base, input int n);
    predict_beats(n);
    for (int k = 0; k < n; k++) begin
      take_beat(exp_tbl[k], stim[base + k].stall);
    end
  endtask

  task automatic check_idle();
    @(negedge clk);
    check_value("out_valid_o", out_valid, 1'b0);
  endtask

  task automatic check_counters();
    for (int i = 0; i < `MERGE_NUM_PORTS; i++) begin
      read_check(REG_CNT0 + apb_addr_t'(4 * i), ref_cnt[i], $sformatf("prdata_o CNT%0d", i));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rdata;
    logic        err;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    in_valid  = '0;
    in_data   = '0;
    out_ready = 1'b0;
    cycle_cnt = 0;
    rr_model  = 2'd0;
    en_model  = 4'b0000;
    void'($urandom(86358));
    fill_table();
    flush_model();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // reset values
    @(negedge clk);
    check_value("out_valid_o", out_valid, 1'b0);
    check_value("in_ready_o", in_ready, 4'hF);
    check_value("pslverr_o", pslverr, 1'b0);
    read_check(REG_CTRL, 32'h0, "prdata_o CTRL");

    // single port 2
    load_steps(A_BASE, 4);
    set_ctrl(32'hF1);
    drain_beats(A_BASE, 4);
    check_idle();

    // all ports preloaded, rotation with stalls
    set_ctrl(32'h00);
    load_steps(B_BASE, 16);
    set_ctrl(32'hF1);
    drain_beats(B_BASE, 16);
    check_idle();

    // port 2 masked, its words wait in the FIFO
    set_ctrl(32'h00);
    load_steps(C_BASE, 8);
    set_ctrl(32'hB1);
    drain_beats(C_BASE, 6);
    check_idle();
    read_check(REG_STATUS, 32'h4, "prdata_o STATUS");
    set_ctrl(32'hF1);
    drain_beats(C_BASE + 6, 2);
    check_idle();

    // counters and an unmapped read
    check_counters();
    apb_read(8'h0C, rdata, err);
    check_value("pslverr_o", err, 1'b1);

    // move the pointer off zero, then flush with words pending
    load_steps(E_ONE, 1);
    drain_beats(E_ONE, 1);
    set_ctrl(32'h00);
    load_steps(E_DROP, 2);
    read_check(REG_STATUS, 32'h9, "prdata_o STATUS");
    apb_write(REG_FLUSH, 32'h1);
    flush_model();
    read_check(REG_STATUS, 32'h0, "prdata_o STATUS");
    check_counters();

    // full round after flush starts again at port 0
    load_steps(E_ROUND, 4);
    set_ctrl(32'hF1);
    drain_beats(E_ROUND, 4);
    check_idle();
    check_counters();

    $display(">>> PASS");
    $finish;
  end

endmodule

//--- hw/stream_merge_top.sv
// four-port stream merger with APB control
// per-port FIFOs feed a round-robin tree onto one tagged output stream

`timescale 1ns/100ps
`include "merge_defines.svh"

module stream_merge_top (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // APB slave
  input  logic                                            psel_i,
  input  logic                                            penable_i,
  input  logic                                            pwrite_i,
  input  merge_cfg_pkg::apb_addr_t                        paddr_i,
  input  logic [31:0]                                     pwdata_i,
  output logic [31:0]                                     prdata_o,
  output logic                                            pready_o,
  output logic                                            pslverr_o,
  // input streams
  input  logic [`MERGE_NUM_PORTS-1:0]                     in_valid_i,
  input  merge_data_pkg::payload_t [`MERGE_NUM_PORTS-1:0] in_data_i,
  output logic [`MERGE_NUM_PORTS-1:0]                     in_ready_o,
  // merged output
  output logic                                            out_valid_o,
  output merge_data_pkg::out_beat_t                       out_beat_o,
  input  logic                                            out_ready_i
);
  import merge_cfg_pkg::*;
  import merge_data_pkg::*;

  merge_ctrl_t                      ctrl;
  logic                             flush;
  logic [`MERGE_NUM_PORTS-1:0]      fifo_en;
  logic [`MERGE_NUM_PORTS-1:0]      fifo_req;
  logic [`MERGE_NUM_PORTS-1:0]      fifo_gnt;
  logic [`MERGE_NUM_PORTS-1:0]      fifo_nempty;
  payload_t [`MERGE_NUM_PORTS-1:0]  fifo_data;
  payload_t                         arb_data;
  port_idx_t                        arb_idx;

  // port enable is the global bit and the port's mask bit
  assign fifo_en = ctrl.port_en & {`MERGE_NUM_PORTS{ctrl.en}};

  for (genvar i = 0; i < `MERGE_NUM_PORTS; i++) begin : gen_port
    port_fifo #(
      .Depth (`MERGE_FIFO_DEPTH)
    ) u_fifo (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .flush_i    (flush),
      .en_i       (fifo_en[i]),
      .in_valid_i (in_valid_i[i]),
      .in_data_i  (in_data_i[i]),
      .in_ready_o (in_ready_o[i]),
      .req_o      (fifo_req[i]),
      .data_o     (fifo_data[i]),
      .gnt_i      (fifo_gnt[i]),
      .nempty_o   (fifo_nempty[i])
    );
  end

  rr_arb_tree #(
    .NumIn    (`MERGE_NUM_PORTS),
    .DataType (payload_t),
    .LockIn   (1'b1)
  ) u_arb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush),
    .req_i   (fifo_req),
    .gnt_o   (fifo_gnt),
    .data_i  (fifo_data),
    .req_o   (out_valid_o),
    .gnt_i   (out_ready_i),
    .data_o  (arb_data),
    .idx_o   (arb_idx)
  );

  // winning index becomes the source tag
  assign out_beat_o = '{data: arb_data, src: arb_idx};

  merge_ctrl_regs u_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .fifo_nempty_i (fifo_nempty),
    .port_gnt_i    (fifo_gnt),
    .ctrl_o        (ctrl),
    .flush_o       (flush)
  );

endmodule

//--- hw/merge_ctrl_regs.sv
// APB register block of the stream merger
// control word, flush pulse, FIFO status and saturating beat counters
// no wait states, pslverr on unmapped or read-only writes

`timescale 1ns/100ps
`include "merge_defines.svh"

module merge_ctrl_regs (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // APB slave
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  merge_cfg_pkg::apb_addr_t     paddr_i,
  input  logic [31:0]                  pwdata_i,
  output logic [31:0]                  prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  // datapath observation
  input  logic [`MERGE_NUM_PORTS-1:0]  fifo_nempty_i,
  input  logic [`MERGE_NUM_PORTS-1:0]  port_gnt_i,
  // control outputs
  output merge_cfg_pkg::merge_ctrl_t   ctrl_o,
  output logic                         flush_o
);
  import merge_cfg_pkg::*;
  import merge_data_pkg::*;

  merge_ctrl_t                       ctrl_q;
  logic                              flush_q;
  beat_cnt_t [`MERGE_NUM_PORTS-1:0]  cnt_q;
  logic                              access;
  logic                              wr_en;
  logic                              addr_hit;
  logic                              addr_ro;

  assign pready_o  = 1'b1;
  assign access    = psel_i & penable_i;
  assign pslverr_o = access & (~addr_hit | (pwrite_i & addr_ro));
  // rejected writes leave the registers alone
  assign wr_en     = access & pwrite_i & ~pslverr_o;
  assign ctrl_o    = ctrl_q;
  assign flush_o   = flush_q;

  //////////////////////////////////////////////////////////////////////
  // address decode and read mux
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    prdata_o = '0;
    addr_hit = 1'b1;
    addr_ro  = 1'b0;
    case (paddr_i)
      REG_CTRL: begin
        prdata_o[0]                      = ctrl_q.en;
        prdata_o[4 +: `MERGE_NUM_PORTS]  = ctrl_q.port_en;
      end
      // write only, reads back as zero
      REG_FLUSH: prdata_o = '0;
      REG_STATUS: begin
        prdata_o[`MERGE_NUM_PORTS-1:0] = fifo_nempty_i;
        addr_ro                        = 1'b1;
      end
      REG_CNT0: begin
        prdata_o = 32'(cnt_q[0]);
        addr_ro  = 1'b1;
      end
      REG_CNT1: begin
        prdata_o = 32'(cnt_q[1]);
        addr_ro  = 1'b1;
      end
      REG_CNT2: begin
        prdata_o = 32'(cnt_q[2]);
        addr_ro  = 1'b1;
      end
      REG_CNT3: begin
        prdata_o = 32'(cnt_q[3]);
        addr_ro  = 1'b1;
      end
      default: addr_hit = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // control word and flush pulse
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q  <= '0;
      flush_q <= 1'b0;
    end else begin
      if (wr_en && paddr_i == REG_CTRL) begin
        ctrl_q.en      <= pwdata_i[0];
        ctrl_q.port_en <= pwdata_i[4 +: `MERGE_NUM_PORTS];
      end
      // single cycle, the next access cannot follow back to back
      flush_q <= wr_en && (paddr_i == REG_FLUSH) && pwdata_i[0];
    end
  end

  // beat counters, stick at all ones, cleared by flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < `MERGE_NUM_PORTS; i++) begin
        if (flush_q) begin
          cnt_q[i] <= '0;
        end else if (port_gnt_i[i] && cnt_q[i] != '1) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  a_flush_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_o |=> !flush_o)
    else $error("merge_ctrl_regs flush longer than one cycle");

endmodule

//--- hw/rr_arb_tree.sv
// logarithmic round-robin arbitration tree
// a rotating pointer steers each level of two-input selectors
// LockIn holds the decision while the output is stalled

`timescale 1ns/100ps

module rr_arb_tree #(
  parameter int unsigned NumIn    = 4,
  parameter type         DataType = logic [31:0],
  parameter bit          LockIn   = 1'b1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  // requesters
  input  logic [NumIn-1:0]         req_i,
  output logic [NumIn-1:0]         gnt_o,
  input  DataType [NumIn-1:0]      data_i,
  // arbitrated output
  output logic                     req_o,
  input  logic                     gnt_i,
  output DataType                  data_o,
  output logic [$clog2(NumIn)-1:0] idx_o
);

  localparam int unsigned NumLevels = $clog2(NumIn);
  localparam int unsigned NumNodes  = 2**NumLevels - 1;

  // node 0 is the root, children of node n sit at 2n+1 and 2n+2
  logic [NumNodes-1:0][NumLevels-1:0] index_nodes;
  DataType [NumNodes-1:0]             data_nodes;
  logic [NumNodes-1:0]                gnt_nodes;
  logic [NumNodes-1:0]                req_nodes;
  logic [NumLevels-1:0]               rr_q;
  logic [NumLevels-1:0]               rr_d;
  // requests as seen by the tree, frozen while locked
  logic [NumIn-1:0]                   req_d;

  assign req_o        = req_nodes[0];
  assign data_o       = data_nodes[0];
  assign idx_o        = index_nodes[0];
  assign gnt_nodes[0] = gnt_i;

  //////////////////////////////////////////////////////////////////////
  // rotation pointer and lock
  //////////////////////////////////////////////////////////////////////

  // one step per output handshake, wraps at NumIn
  assign rr_d = (req_o && gnt_i) ?
                ((rr_q == NumLevels'(NumIn - 1)) ? '0 : rr_q + 1'b1) : rr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (flush_i) begin
      rr_q <= '0;
    end else begin
      rr_q <= rr_d;
    end
  end

  if (LockIn) begin : gen_lock
    logic             lock_q;
    logic [NumIn-1:0] req_q;

    assign req_d = lock_q ? req_q : req_i;

    // stalled output keeps the snapshot of requests that won
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        lock_q <= 1'b0;
        req_q  <= '0;
      end else if (flush_i) begin
        lock_q <= 1'b0;
        req_q  <= '0;
      end else begin
        lock_q <= req_o & ~gnt_i;
        req_q  <= req_d;
      end
    end

    a_lock_idx : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
      req_o && !gnt_i |=> idx_o == $past(idx_o))
      else $error("rr_arb_tree decision changed under lock");
  end else begin : gen_no_lock
    assign req_d = req_i;
  end

  //////////////////////////////////////////////////////////////////////
  // selector tree
  //////////////////////////////////////////////////////////////////////
  for (genvar level = 0; level < NumLevels; level++) begin : gen_levels
    for (genvar l = 0; l < 2**level; l++) begin : gen_nodes
      localparam int unsigned Node  = 2**level - 1 + l;
      localparam int unsigned Child = 2**(level + 1) - 1 + 2 * l;
      logic sel;

      if (level == NumLevels - 1) begin : gen_leaf
        // leaf level reads the inputs directly
        if (2 * l < NumIn - 1) begin : gen_pair
          assign req_nodes[Node]   = req_d[2*l] | req_d[2*l+1];
          // take the odd input when the even one is idle or the pointer says so
          assign sel               = ~req_d[2*l] | (req_d[2*l+1] & rr_q[0]);
          assign index_nodes[Node] = NumLevels'(sel);
          assign data_nodes[Node]  = sel ? data_i[2*l+1] : data_i[2*l];
          assign gnt_o[2*l]        = gnt_nodes[Node] & req_d[2*l] & ~sel;
          assign gnt_o[2*l+1]      = gnt_nodes[Node] & req_d[2*l+1] & sel;
        end else if (2 * l == NumIn - 1) begin : gen_single
          // odd input count, last leaf has one input
          assign sel               = 1'b0;
          assign req_nodes[Node]   = req_d[2*l];
          assign index_nodes[Node] = '0;
          assign data_nodes[Node]  = data_i[2*l];
          assign gnt_o[2*l]        = gnt_nodes[Node] & req_d[2*l];
        end else begin : gen_empty
          assign sel               = 1'b0;
          assign req_nodes[Node]   = 1'b0;
          assign index_nodes[Node] = '0;
          assign data_nodes[Node]  = '0;
        end
      end else begin : gen_inner
        localparam int unsigned Lsb = NumLevels - level - 2;

        assign req_nodes[Node]   = req_nodes[Child] | req_nodes[Child+1];
        // higher levels use the higher pointer bits
        assign sel               = ~req_nodes[Child] |
                                   (req_nodes[Child+1] & rr_q[NumLevels-1-level]);
        assign index_nodes[Node] = sel ?
          NumLevels'({1'b1, index_nodes[Child+1][Lsb:0]}) :
          NumLevels'({1'b0, index_nodes[Child][Lsb:0]});
        assign data_nodes[Node]  = sel ? data_nodes[Child+1] : data_nodes[Child];
        assign gnt_nodes[Child]   = gnt_nodes[Node] & ~sel;
        assign gnt_nodes[Child+1] = gnt_nodes[Node] & sel;
      end
    end
  end

  // at most one winner
  a_onehot_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    $onehot0(gnt_o))
    else $error("rr_arb_tree grant not one-hot");

  // no input grant without the downstream taking the beat
  a_gnt_in : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    |gnt_o |-> gnt_i)
    else $error("rr_arb_tree grant without gnt_i");

endmodule

//--- hw/port_fifo.sv
// per-port input FIFO of the stream merger
// valid/ready on the write side, req/gnt towards the arbiter
// en_i only masks the request, buffered words stay put

`timescale 1ns/100ps
`include "merge_defines.svh"

module port_fifo #(
  parameter int unsigned Depth = `MERGE_FIFO_DEPTH
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     en_i,
  // upstream source
  input  logic                     in_valid_i,
  input  merge_data_pkg::payload_t in_data_i,
  output logic                     in_ready_o,
  // towards the arbiter
  output logic                     req_o,
  output merge_data_pkg::payload_t data_o,
  input  logic                     gnt_i,
  output logic                     nempty_o
);
  import merge_data_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            full;
  logic            push;
  logic            pop;

  assign full       = (cnt_q == CntW'(Depth));
  assign nempty_o   = (cnt_q != '0);
  // ready only looks at the fill level, never at the enables
  assign in_ready_o = ~full;
  assign req_o      = nempty_o & en_i;
  assign data_o     = mem_q[rd_ptr_q];
  assign push       = in_valid_i & ~full;
  assign pop        = gnt_i & nempty_o;

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  // pointers and fill count, flush drops everything
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // a write never lands on a slot that still holds an unread word
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> !((wr_ptr_q == rd_ptr_q) && (cnt_q != '0)))
    else $error("port_fifo push into a full buffer");

  // arbiter only grants a port that is requesting
  a_gnt_needs_req : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    gnt_i |-> req_o)
    else $error("port_fifo grant without request");

endmodule

//--- hw/merge_data_pkg.sv
// data-side types of the stream merger
// payload word, source index, beat counter and the merged output beat

`include "merge_defines.svh"

package merge_data_pkg;

  // one stream word
  typedef logic [`MERGE_DATA_W-1:0] payload_t;

  // index of the source port a beat came from
  typedef logic [$clog2(`MERGE_NUM_PORTS)-1:0] port_idx_t;

  // per-port beat counter, saturates at all ones
  typedef logic [15:0] beat_cnt_t;

  // merged output beat
  // data sits in the upper bits, source tag in the low bits
  typedef struct packed {
    payload_t  data;
    port_idx_t src;
  } out_beat_t;

endpackage

//--- hw/merge_cfg_pkg.sv
// control-side types of the stream merger
// APB address type, register map offsets and the control word

`include "merge_defines.svh"

package merge_cfg_pkg;

  // byte address on the APB bus
  typedef logic [`MERGE_APB_AW-1:0] apb_addr_t;

  // control word, global enable plus one enable bit per port
  typedef struct packed {
    logic [`MERGE_NUM_PORTS-1:0] port_en;
    logic                        en;
  } merge_ctrl_t;

  //////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////
  localparam apb_addr_t REG_CTRL   = 8'h00;
  localparam apb_addr_t REG_FLUSH  = 8'h04;
  localparam apb_addr_t REG_STATUS = 8'h08;
  // per-port beat counters, read only
  localparam apb_addr_t REG_CNT0   = 8'h10;
  localparam apb_addr_t REG_CNT1   = 8'h14;
  localparam apb_addr_t REG_CNT2   = 8'h18;
  localparam apb_addr_t REG_CNT3   = 8'h1C;

endpackage

//--- include/merge_defines.svh
// stream merger build constants
// port count, payload width, FIFO depth and APB address width

`ifndef MERGE_DEFINES_SVH
`define MERGE_DEFINES_SVH

// number of upstream input ports
`define MERGE_NUM_PORTS 4

// payload width of one stream word
`define MERGE_DATA_W 32

// entries in each per-port FIFO
`define MERGE_FIFO_DEPTH 4

// APB address width seen by the register block
`define MERGE_APB_AW 8

`endif
